//--- testbench/axi4s_mux_tests.txt
# test <name> <egress ready: always|random> <round-robin check: 0|1>
# pkt <src> <beats> <bytes in last beat> <seed hex> <tid> <tdest> <tuser hex>
test single_src always 0
pkt 0 3 4 10 0 1 a5
pkt 0 1 2 40 0 2 5a
pkt 0 5 3 80 0 3 11
pkt 0 2 1 f0 0 4 22

test contention always 0
pkt 0 4 4 00 0 1 01
pkt 1 3 2 30 1 2 02
pkt 0 1 4 50 0 3 03
pkt 1 6 1 70 1 4 04
pkt 0 2 3 a0 0 5 05
pkt 1 2 4 c0 1 6 06

test fairness always 1
pkt 0 2 4 08 0 1 10
pkt 1 2 4 18 1 1 20
pkt 0 3 4 28 0 2 30
pkt 1 1 4 38 1 2 40
pkt 0 2 2 48 0 3 50
pkt 1 3 3 58 1 3 60
pkt 0 1 1 68 0 4 70
pkt 1 2 4 78 1 4 80

test backpressure random 0
pkt 0 4 4 00 0 1 01
pkt 1 3 2 30 1 2 02
pkt 0 1 4 50 0 3 03
pkt 1 6 1 70 1 4 04
pkt 0 2 3 a0 0 5 05
pkt 1 2 4 c0 1 6 06

//--- project.f
rtl/axi4s_pkg.sv
rtl/arb_rr.sv
rtl/axi4s_skid_buffer.sv
rtl/axi4s_out_reg.sv
rtl/axi4s_mux.sv
testbench/axi4s_mux_checker.sv
testbench/axi4s_mux_monitor.sv
testbench/axi4s_mux_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the multiplexer testbench with Verilator.
# Exits non-zero when the build fails, the run fails or the log
# contains the failure message.

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
   --top-module axi4s_mux_tb \
   -f project.f \
   -Mdir "$OBJ" -o axi4s_mux_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

"./$OBJ/axi4s_mux_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

echo "simulation finished without failure"
exit 0

//--- testbench/axi4s_mux_tb.sv
/*
 * Testbench top for the AXI4-Stream packet multiplexer.
 * Reads the test list, drives both ingress ports and the egress ready,
 * and leaves all comparing to the monitor.
 */

`timescale 1ns/1ps
`default_nettype none

module axi4s_mux_tb;
   import axi4s_pkg::*;

   localparam int N      = 2;
   localparam int CLK_NS = 8;

   // one packet line of the test file.
   typedef struct packed {
      int test;
      int src;
      int beats;
      int tail;
      int seed;
      int tid;
      int tdest;
      int tuser;
   } pkt_rec_t;

   logic          aclk;
   logic          reset;
   logic [N-1:0]  in_valid;
   axi4s_beat_t   in_beat [N];
   logic [N-1:0]  in_ready;
   logic          out_valid;
   axi4s_beat_t   out_beat;
   logic          out_ready;

   string         t_name [$];
   bit            t_random [$];
   bit            t_alt [$];
   pkt_rec_t      pkts [$];
   // beats still to be sent on each ingress port.
   axi4s_beat_t   drv_q [N][$];
   int            total_beats;
   bit            random_ready;
   bit            loaded;
   int            seed = 32'h9943_7ab2;

   axi4s_mux #(
      .N (N)
   ) u_axi4s_mux (
      .aclk      (aclk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_beat   (in_beat),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat),
      .out_ready (out_ready)
   );

   axi4s_mux_monitor #(
      .N (N)
   ) u_monitor (
      .aclk      (aclk),
      .reset     (reset),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_beat  (out_beat),
      .out_ready (out_ready)
   );

   // -------------------------------------------------------------------------
   // clock, egress ready and watchdog
   // -------------------------------------------------------------------------

   initial begin
      aclk = 1'b0;
      forever #(CLK_NS / 2) aclk = ~aclk;
   end

   // egress ready changes 1 ns after each edge and is random or held high.
   initial begin
      int r;
      out_ready = 1'b0;
      forever begin
         @(posedge aclk);
         #1;
         r = $random(seed);
         out_ready = random_ready ? r[0] : 1'b1;
      end
   end

   // 200 cycles per beat in the file plus a margin.
   initial begin
      wait (loaded);
      #((total_beats * 200 + 500) * CLK_NS);
      $display("timeout: traffic did not drain within %0d cycles",
               total_beats * 200 + 500);
      $display("test failed");
      $finish;
   end

   // -------------------------------------------------------------------------
   // test file and packet contents
   // -------------------------------------------------------------------------

   // payload counts up from the seed byte.
   // a short last beat leaves its upper lanes clear.
   function automatic axi4s_beat_t make_beat(input pkt_rec_t p, input int b);
      axi4s_beat_t beat;
      int          nb;
      beat = '0;
      nb   = (b == p.beats - 1) ? p.tail : DATA_BYTE_WID;
      for (int j = 0; j < nb; j++) begin
         beat.tdata[j] = 8'((p.seed + b * DATA_BYTE_WID + j) & 255);
         beat.tkeep[j] = 1'b1;
      end
      beat.tlast = (b == p.beats - 1);
      beat.tid   = TID_WID'(p.tid);
      beat.tdest = TDEST_WID'(p.tdest);
      beat.tuser = TUSER_WID'(p.tuser);
      return beat;
   endfunction

   task automatic load_tests();
      int       fd;
      int       n;
      string    line;
      string    kw;
      string    name;
      string    mode;
      int       alt;
      pkt_rec_t p;
      total_beats = 0;
      fd = $fopen("testbench/axi4s_mux_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open the test list file");
         u_monitor.count_error();
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // blank lines and comment lines carry nothing.
         if (line.len() < 2 || line.substr(0, 0) == "#") continue;
         n = $sscanf(line, "%s", kw);
         if (kw == "test") begin
            n = $sscanf(line, "%s %s %s %d", kw, name, mode, alt);
            t_name.push_back(name);
            t_random.push_back(mode == "random");
            t_alt.push_back(alt != 0);
         end else if (kw == "pkt") begin
            p      = '0;
            p.test = t_name.size() - 1;
            n = $sscanf(line, "%s %d %d %d %h %d %d %h", kw, p.src, p.beats,
                        p.tail, p.seed, p.tid, p.tdest, p.tuser);
            pkts.push_back(p);
            total_beats += p.beats;
         end
      end
      $fclose(fd);
   endtask

   // -------------------------------------------------------------------------
   // ingress driver
   // -------------------------------------------------------------------------

   // ready is taken at the falling edge where it is stable until the next rise.
   task automatic drive_port(input int p);
      axi4s_beat_t b;
      bit          rdy;
      while (drv_q[p].size() > 0) begin
         b           = drv_q[p].pop_front();
         in_valid[p] = 1'b1;
         in_beat[p]  = b;
         do begin
            @(negedge aclk);
            rdy = in_ready[p];
            @(posedge aclk);
            #1;
         end while (!rdy);
         in_valid[p] = 1'b0;
      end
   endtask

   // -------------------------------------------------------------------------
   // test sequence
   // -------------------------------------------------------------------------

   initial begin
      reset        = 1'b1;
      in_valid     = '0;
      in_beat      = '{default: '0};
      random_ready = 1'b0;
      loaded       = 1'b0;
      load_tests();
      loaded = 1'b1;

      u_monitor.start_test("reset_values", 1'b0);
      repeat (5) @(posedge aclk);
      #1;
      reset = 1'b0;
      @(posedge aclk);
      #1;
      u_monitor.end_test();

      for (int t = 0; t < t_name.size(); t++) begin
         random_ready = t_random[t];
         u_monitor.start_test(t_name[t], t_alt[t]);
         foreach (pkts[k]) begin
            if (pkts[k].test == t) begin
               for (int b = 0; b < pkts[k].beats; b++) begin
                  drv_q[pkts[k].src].push_back(make_beat(pkts[k], b));
                  u_monitor.expect_beat(pkts[k].src, make_beat(pkts[k], b));
               end
            end
         end
         fork
            drive_port(0);
            drive_port(1);
         join
         // wait until the monitor has seen every expected beat.
         while (u_monitor.beats_left() > 0) @(negedge aclk);
         repeat (2) @(posedge aclk);
         #1;
         u_monitor.end_test();
      end

      $display("tests run %0d, tests with errors %0d, errors %0d, assertion failures %0d",
               u_monitor.tests_run, u_monitor.tests_bad, u_monitor.error_count,
               u_axi4s_mux.u_checker.fail_count);
      if (u_monitor.error_count == 0 && u_axi4s_mux.u_checker.fail_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule : axi4s_mux_tb

`default_nettype wire

//--- testbench/axi4s_mux_monitor.sv
/*
 * Egress monitor for the multiplexer testbench.
 * Holds the expected beats per source port, rebuilds packets from the egress
 * port, compares them and prints one line per test.
 */

`timescale 1ns/1ps
`default_nettype none

module axi4s_mux_monitor #(
   parameter int N = 2
) (
   input  logic                    aclk,
   input  logic                    reset,
   input  logic [N-1:0]            in_ready,
   input  logic                    out_valid,
   input  axi4s_pkg::axi4s_beat_t  out_beat,
   input  logic                    out_ready
);
   import axi4s_pkg::*;

   // expected beats, sorted by source port.
   axi4s_beat_t exp_q [N][$];
   int          pkts_left [N];
   string       test_name;
   bit          alt_check;
   int          prev_tid;
   bit          in_pkt;
   int          cur_tid;
   int          test_errors;
   int          error_count;
   int          tests_run;
   int          tests_bad;
   // reset as seen at the last rising edge.
   bit          rst_d;

   task automatic start_test(input string name, input bit alt);
      test_name   = name;
      alt_check   = alt;
      prev_tid    = -1;
      in_pkt      = 1'b0;
      test_errors = 0;
   endtask

   task automatic expect_beat(input int port, input axi4s_beat_t beat);
      exp_q[port].push_back(beat);
      if (beat.tlast) pkts_left[port]++;
   endtask

   function automatic int beats_left();
      int n;
      n = 0;
      for (int p = 0; p < N; p++) n += exp_q[p].size();
      return n;
   endfunction

   task automatic count_error();
      test_errors++;
      error_count++;
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("done %-14s ok", test_name);
      end else begin
         tests_bad++;
         $display("done %-14s %0d errors", test_name, test_errors);
      end
   endtask

   // -------------------------------------------------------------------------
   // per-beat comparison
   // -------------------------------------------------------------------------

   task automatic check_beat(input axi4s_beat_t b);
      axi4s_beat_t exp;
      int          tid;
      tid = int'(b.tid);
      if (tid >= N) begin
         $display("%s: egress beat carries tid %0d, which is no source port",
                  test_name, tid);
         count_error();
         return;
      end
      // a packet must not mix sources.
      if (in_pkt && tid != cur_tid) begin
         $display("[FAIL] %s: packet tid, expected %0d, actual %0d",
                  test_name, cur_tid, tid);
         count_error();
      end
      // round robin, a waiting port wins over the one just served.
      if (!in_pkt && alt_check && prev_tid == tid) begin
         for (int p = 0; p < N; p++) begin
            if (p != tid && pkts_left[p] > 0) begin
               $display("[FAIL] %s: packet source, expected tid %0d, actual %0d",
                        test_name, p, tid);
               count_error();
               break;
            end
         end
      end
      if (exp_q[tid].size() == 0) begin
         $display("%s: port %0d sent a beat beyond its expected packets",
                  test_name, tid);
         count_error();
      end else begin
         exp = exp_q[tid].pop_front();
         if (b !== exp) begin
            $display("[FAIL] %s: port %0d beat, expected %h, actual %h",
                     test_name, tid, exp, b);
            count_error();
         end
      end
      in_pkt  = !b.tlast;
      cur_tid = tid;
      if (b.tlast) begin
         pkts_left[tid]--;
         prev_tid = tid;
      end
   endtask

   always @(posedge aclk) begin
      rst_d <= reset;
   end

   // outputs are flops and sampled at the falling edge.
   always @(negedge aclk) begin
      if (rst_d) begin
         // covers every reset cycle and the first cycle after it.
         if (out_valid !== 1'b0 || in_ready !== '0) begin
            $display("[FAIL] %s: out_valid/in_ready, expected 0/%0h, actual %b/%b",
                     test_name, {N{1'b0}}, out_valid, in_ready);
            count_error();
         end
      end else if (out_valid === 1'b1 && out_ready === 1'b1) begin
         check_beat(out_beat);
      end
   end

endmodule : axi4s_mux_monitor

`default_nettype wire

//--- testbench/axi4s_mux_checker.sv
/*
 * Protocol assertions for the multiplexer, bound into axi4s_mux.
 * Covers egress stability under back-pressure and the arbiter grant rules.
 */

`timescale 1ns/1ps
`default_nettype none

module axi4s_mux_checker #(
   parameter int N = 2
) (
   input  logic                    aclk,
   input  logic                    reset,
   input  logic                    out_valid,
   input  axi4s_pkg::axi4s_beat_t  out_beat,
   input  logic                    out_ready,
   input  logic [N-1:0]            grant,
   input  axi4s_pkg::arb_state_t   state
);
   import axi4s_pkg::*;

   // number of assertion failures so far.
   int fail_count = 0;

   initial begin
      assert (N >= 2 && N <= N_MAX)
      else begin
         fail_count++;
         $error("port count %0d out of range", N);
      end
   end

   // a stalled egress beat stays put until it is taken.
   a_out_hold: assert property (@(posedge aclk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
      else begin
         fail_count++;
         $error("egress beat changed or dropped while stalled");
      end

   // at most one port granted.
   a_grant_onehot: assert property (@(posedge aclk) disable iff (reset)
      $onehot0(grant))
      else begin
         fail_count++;
         $error("more than one port granted");
      end

   // grant is frozen for the whole packet.
   a_grant_locked: assert property (@(posedge aclk) disable iff (reset)
      state == ARB_LOCKED |-> $stable(grant))
      else begin
         fail_count++;
         $error("grant moved while the arbiter was locked");
      end

endmodule : axi4s_mux_checker

bind axi4s_mux axi4s_mux_checker #(
   .N (N)
) u_checker (
   .aclk      (aclk),
   .reset     (reset),
   .out_valid (out_valid),
   .out_beat  (out_beat),
   .out_ready (out_ready),
   .grant     (grant),
   .state     (u_arb_rr.state)
);

`default_nettype wire

//--- rtl/axi4s_mux.sv
/*
 * AXI4-Stream packet multiplexer, the top level.
 * Merges N ingress streams onto one egress stream a whole packet at a time,
 * with round-robin arbitration that skips idle ports.
 */

`timescale 1ns/1ps
`default_nettype none

module axi4s_mux #(
   // number of ingress ports, 2 to N_MAX.
   parameter int N = 2
) (
   input  logic                    aclk,
   input  logic                    reset,
   input  logic [N-1:0]            in_valid,
   input  axi4s_pkg::axi4s_beat_t  in_beat [N],
   output logic [N-1:0]            in_ready,
   output logic                    out_valid,
   output axi4s_pkg::axi4s_beat_t  out_beat,
   input  logic                    out_ready
);
   import axi4s_pkg::*;

   // skid buffer outputs, one per ingress port.
   logic [N-1:0]         buf_valid;
   axi4s_beat_t          buf_beat [N];
   logic [N-1:0]         buf_ready;

   // arbiter handshake.
   logic [N-1:0]         req;
   logic [N-1:0]         ack;
   logic [N-1:0]         grant;
   logic [$clog2(N)-1:0] sel;

   // selected stream into the egress stage.
   logic                 mid_valid;
   axi4s_beat_t          mid_beat;
   logic                 mid_ready;

   // ------------------------------------------------------------------------
   // ingress buffers and arbiter handshake
   // ------------------------------------------------------------------------

   for (genvar g = 0; g < N; g++) begin : g_in
      axi4s_skid_buffer u_skid (
         .aclk       (aclk),
         .reset      (reset),
         .up_valid   (in_valid[g]),
         .up_beat    (in_beat[g]),
         .up_ready   (in_ready[g]),
         .down_valid (buf_valid[g]),
         .down_beat  (buf_beat[g]),
         .down_ready (buf_ready[g])
      );

      // a pending beat is a request.
      assign req[g] = buf_valid[g];

      // only the granted buffer sees egress ready.
      assign buf_ready[g] = grant[g] && mid_ready;

      // ack on the accepted last beat releases the grant.
      assign ack[g] = buf_valid[g] && buf_ready[g] && buf_beat[g].tlast;
   end : g_in

   arb_rr #(
      .N (N)
   ) u_arb_rr (
      .aclk  (aclk),
      .reset (reset),
      .req   (req),
      .ack   (ack),
      .grant (grant),
      .sel   (sel)
   );

   // ------------------------------------------------------------------------
   // selection mux and egress stage
   // ------------------------------------------------------------------------

   // valid is qualified by grant, so nothing leaks out between packets.
   assign mid_valid = |(buf_valid & grant);
   assign mid_beat  = buf_beat[sel];

   axi4s_out_reg u_out_reg (
      .aclk       (aclk),
      .reset      (reset),
      .up_valid   (mid_valid),
      .up_beat    (mid_beat),
      .up_ready   (mid_ready),
      .down_valid (out_valid),
      .down_beat  (out_beat),
      .down_ready (out_ready)
   );

endmodule : axi4s_mux

`default_nettype wire

//--- rtl/axi4s_out_reg.sv
/*
 * Fully registered egress stage for one AXI4-Stream.
 * valid, data and ready all come from flops; a main and a skid register
 * give one cycle of latency and full throughput.
 */

`timescale 1ns/1ps
`default_nettype none

module axi4s_out_reg (
   input  logic                    aclk,
   input  logic                    reset,
   input  logic                    up_valid,
   input  axi4s_pkg::axi4s_beat_t  up_beat,
   output logic                    up_ready,
   output logic                    down_valid,
   output axi4s_pkg::axi4s_beat_t  down_beat,
   input  logic                    down_ready
);
   import axi4s_pkg::*;

   // main register drives the egress port directly.
   logic        main_valid;
   axi4s_beat_t main_beat;
   // skid register takes the beat accepted while main stalls.
   logic        skid_valid;
   axi4s_beat_t skid_beat;

   logic        in_fire;
   logic        main_load;
   logic        skid_valid_n;

   assign down_valid = main_valid;
   assign down_beat  = main_beat;

   assign in_fire = up_valid && up_ready;

   // main can take a new beat when empty or when it drains this cycle.
   assign main_load = !main_valid || down_ready;

   // ------------------------------------------------------------------------
   // control
   // ------------------------------------------------------------------------

   always_comb begin
      skid_valid_n = skid_valid;
      if (main_load) begin
         // the skid beat moves into main.
         skid_valid_n = 1'b0;
      end else if (in_fire) begin
         skid_valid_n = 1'b1;
      end
   end

   always_ff @(posedge aclk) begin
      if (reset) begin
         main_valid <= 1'b0;
         skid_valid <= 1'b0;
         up_ready   <= 1'b0;
      end else begin
         if (main_load) begin
            main_valid <= skid_valid || in_fire;
         end
         skid_valid <= skid_valid_n;
         // registered ready, low while the skid register is occupied.
         up_ready   <= !skid_valid_n;
      end
   end

   // ------------------------------------------------------------------------
   // payload
   // ------------------------------------------------------------------------

   always_ff @(posedge aclk) begin
      if (main_load) begin
         // the older skid beat goes out before any new one.
         main_beat <= skid_valid ? skid_beat : up_beat;
      end else if (in_fire) begin
         skid_beat <= up_beat;
      end
   end

endmodule : axi4s_out_reg

`default_nettype wire

//--- rtl/axi4s_skid_buffer.sv
/*
 * Ingress skid buffer for one AXI4-Stream port.
 * Beats pass through with no latency while downstream is ready; up_ready
 * comes from a flop and one spare register catches the beat in flight.
 */

`timescale 1ns/1ps
`default_nettype none

module axi4s_skid_buffer (
   input  logic                    aclk,
   input  logic                    reset,
   input  logic                    up_valid,
   input  axi4s_pkg::axi4s_beat_t  up_beat,
   output logic                    up_ready,
   output logic                    down_valid,
   output axi4s_pkg::axi4s_beat_t  down_beat,
   input  logic                    down_ready
);
   import axi4s_pkg::*;

   // spare register, filled when downstream stalls under an accepted beat.
   logic        spare_valid;
   axi4s_beat_t spare_beat;

   logic        up_fire;
   logic        spare_valid_n;

   // upstream transfer this cycle.
   assign up_fire = up_valid && up_ready;

   // ------------------------------------------------------------------------
   // output side
   // ------------------------------------------------------------------------

   // the spare always drains first, it holds the older beat.
   // otherwise the accepted upstream beat passes straight through.
   assign down_valid = spare_valid || up_fire;
   assign down_beat  = spare_valid ? spare_beat : up_beat;

   // ------------------------------------------------------------------------
   // spare control
   // ------------------------------------------------------------------------

   always_comb begin
      if (spare_valid) begin
         // up_ready is low here, so only a drain can happen.
         spare_valid_n = !down_ready;
      end else begin
         // an accepted beat that downstream refuses goes to the spare.
         spare_valid_n = up_fire && !down_ready;
      end
   end

   always_ff @(posedge aclk) begin
      if (reset) begin
         spare_valid <= 1'b0;
         up_ready    <= 1'b0;
      end else begin
         spare_valid <= spare_valid_n;
         // ready only while the spare can take a stalled beat.
         up_ready    <= !spare_valid_n;
      end
   end

   // payload only, loaded with the beat that missed the downstream edge.
   always_ff @(posedge aclk) begin
      if (!spare_valid && up_fire && !down_ready) begin
         spare_beat <= up_beat;
      end
   end

endmodule : axi4s_skid_buffer

`default_nettype wire

//--- rtl/arb_rr.sv
/*
 * Work-conserving round-robin arbiter with packet-long grants.
 * A port is granted when it requests and keeps the grant until its ack,
 * which the user raises on the accepted last beat of the packet.
 */

`timescale 1ns/1ps
`default_nettype none

module arb_rr #(
   parameter int N = 2
) (
   input  logic                 aclk,
   input  logic                 reset,
   input  logic [N-1:0]         req,
   input  logic [N-1:0]         ack,
   output logic [N-1:0]         grant,
   output logic [$clog2(N)-1:0] sel
);
   import axi4s_pkg::*;

   localparam int SEL_WID = $clog2(N);

   arb_state_t         state;
   // port served last; the search starts just after it.
   logic [SEL_WID-1:0] ptr;
   // port held while locked.
   logic [SEL_WID-1:0] sel_q;

   logic               pick_found;
   logic [SEL_WID-1:0] pick_sel;
   logic               grant_vld;

   // ------------------------------------------------------------------------
   // cyclic search
   // ------------------------------------------------------------------------

   // first requester after ptr in cyclic order.
   // idle ports are simply skipped, so no cycle is spent on them.
   always_comb begin
      pick_found = 1'b0;
      pick_sel   = ptr;
      for (int k = 1; k <= N; k++) begin
         if (!pick_found && req[(int'(ptr) + k) % N]) begin
            pick_found = 1'b1;
            pick_sel   = SEL_WID'((int'(ptr) + k) % N);
         end
      end
   end

   // ------------------------------------------------------------------------
   // grant and select
   // ------------------------------------------------------------------------

   // in idle the choice drives sel straight away, in locked the held port.
   always_comb begin
      if (state == ARB_LOCKED) begin
         sel       = sel_q;
         grant_vld = 1'b1;
      end else begin
         sel       = pick_sel;
         grant_vld = pick_found;
      end
      grant = '0;
      for (int i = 0; i < N; i++) begin
         if (grant_vld && sel == SEL_WID'(i)) begin
            grant[i] = 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------------
   // state and pointer
   // ------------------------------------------------------------------------

   always_ff @(posedge aclk) begin
      if (reset) begin
         state <= ARB_IDLE;
         // port 0 wins the first search.
         ptr   <= SEL_WID'(N - 1);
         sel_q <= '0;
      end else begin
         unique case (state)
            ARB_IDLE: begin
               if (pick_found) begin
                  sel_q <= pick_sel;
                  // a one-beat packet may finish in the grant cycle.
                  if (ack[pick_sel]) begin
                     ptr <= pick_sel;
                  end else begin
                     state <= ARB_LOCKED;
                  end
               end
            end
            ARB_LOCKED: begin
               // release after the last beat, next cycle searches again.
               if (ack[sel_q]) begin
                  state <= ARB_IDLE;
                  ptr   <= sel_q;
               end
            end
         endcase
      end
   end

endmodule : arb_rr

`default_nettype wire

//--- rtl/axi4s_pkg.sv
/*
 * Shared types and widths for the AXI4-Stream packet multiplexer.
 * RTL and testbench import this package for the beat layout and the arbiter
 * state encoding.
 */

`default_nettype none

package axi4s_pkg;

   // ------------------------------------------------------------------------
   // beat widths
   // ------------------------------------------------------------------------

   // bytes per beat; the beat struct below is sized from it.
   localparam int DATA_BYTE_WID = 4;

   // sideband widths, carried through without any routing.
   localparam int TID_WID   = 4;
   localparam int TDEST_WID = 4;
   localparam int TUSER_WID = 8;

   // upper bound on the number of ingress ports.
   localparam int N_MAX = 4;

   // ------------------------------------------------------------------------
   // beat type
   // ------------------------------------------------------------------------

   // one AXI4-Stream beat without its valid/ready handshake.
   // tdata is byte indexed, so tdata[0] is the first byte on the wire.
   typedef struct packed {
      logic [DATA_BYTE_WID-1:0][7:0] tdata;
      // one strobe per data byte.
      logic [DATA_BYTE_WID-1:0]      tkeep;
      // marks the final beat of a packet.
      logic                          tlast;
      // tid holds the source port in this design's traffic.
      logic [TID_WID-1:0]            tid;
      logic [TDEST_WID-1:0]          tdest;
      logic [TUSER_WID-1:0]          tuser;
   } axi4s_beat_t;

   // ------------------------------------------------------------------------
   // arbiter state
   // ------------------------------------------------------------------------

   // idle searches for a requester, locked holds the grant until the
   // last beat of the packet is acknowledged.
   typedef enum logic [0:0] {
      ARB_IDLE   = 1'b0,
      ARB_LOCKED = 1'b1
   } arb_state_t;

endpackage : axi4s_pkg

`default_nettype wire
